// ==== rtl/rhPkg.sv ====
package rhPkg;

   //////////////////////////////////////////////////
   // Word types
   //////////////////////////////////////////////////

   // One device bus or DMA word
   typedef logic [35:0] rhWord_t;

   // Bus address, bit 0 always zero
   typedef logic [17:0] rhAddr_t;

   // Register select
   typedef logic [2:0]  rhRegSel_t;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   localparam rhRegSel_t RegCs1 = 3'd0;
   localparam rhRegSel_t RegWc  = 3'd1;
   localparam rhRegSel_t RegBa  = 3'd2;
   localparam rhRegSel_t RegDa  = 3'd3;
   localparam rhRegSel_t RegCs2 = 3'd4;

   // CS1 fields, LSB position for the wide ones
   localparam int Cs1Go    = 0;
   localparam int Cs1Fun   = 1;
   localparam int FunWidth = 5;
   localparam int Cs1Rdy   = 7;
   localparam int Cs1Bae   = 8;
   localparam int BaeWidth = 2;

   // CS2 fields
   localparam int Cs2Bai = 3;
   localparam int Cs2Clr = 5;

   // Read data function, CS1 code 071 with GO
   localparam logic [4:0] FunRead = 5'b11100;

endpackage

// ==== rtl/rhSiloIf.sv ====
`timescale 1ns/1ns

interface rhSiloIf #(
   parameter int SiloDepth = 8
);

   // Drive side
   logic             push;
   rhPkg::rhWord_t   pushData;
   logic             full;

   // Bus side
   logic             pop;
   rhPkg::rhWord_t   popData;
   logic             empty;

   // Pointer wrap relies on a power of two
   initial
   begin
      assert (SiloDepth >= 2 && (SiloDepth & (SiloDepth - 1)) == 0)
         else $error("rhSiloIf: SiloDepth %0d is not a power of two", SiloDepth);
   end

   modport producer (output push, output pushData, input full);

   modport buffer (input push, input pushData, output full,
                   input pop, output popData, output empty);

   modport consumer (output pop, input popData, input empty);

endinterface

// ==== rtl/rhRegs.sv ====
`timescale 1ns/1ns

module rhRegs (
   input  logic               clk,
   input  logic               rst,
   input  logic               devReset,
   input  rhPkg::rhRegSel_t   devSel,
   input  logic               devWrite,
   input  logic               devLoByte,
   input  logic               devHiByte,
   input  rhPkg::rhWord_t     devDataIn,
   input  rhPkg::rhAddr_t     busAddr,
   input  logic               wordDone,
   output rhPkg::rhWord_t     devDataOut,
   output logic               cs1Write,
   output logic               baWrite,
   output logic               ctlClr,
   output logic               rdy,
   output logic               bai,
   output logic               start,
   output logic [15:0]        daValue,
   output logic [15:0]        wcCount
);

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////

   logic                            wcWrite;
   logic                            daWrite;
   logic                            cs2Write;
   logic                            goWrite;
   logic [rhPkg::FunWidth-1:0]      fun;
   logic [15:0]                     wc;
   logic [15:0]                     da;
   rhPkg::rhWord_t                  cs1Word;
   rhPkg::rhWord_t                  cs2Word;

   assign cs1Write = devWrite && devSel == rhPkg::RegCs1;
   assign wcWrite  = devWrite && devSel == rhPkg::RegWc;
   assign baWrite  = devWrite && devSel == rhPkg::RegBa;
   assign daWrite  = devWrite && devSel == rhPkg::RegDa;
   assign cs2Write = devWrite && devSel == rhPkg::RegCs2;

   // Controller clear from CS2 or the bus reset
   assign ctlClr = devReset || (cs2Write && devLoByte && devDataIn[rhPkg::Cs2Clr]);

   // GO with the read function, only when idle
   assign goWrite = cs1Write && devLoByte && devDataIn[rhPkg::Cs1Go] && rdy && !ctlClr &&
                    devDataIn[rhPkg::Cs1Fun +: rhPkg::FunWidth] == rhPkg::FunRead;

   //////////////////////////////////////////////////
   // Control registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fun   <= '0;
         rdy   <= 1'b1;
         start <= 1'b0;
         wc    <= '0;
         da    <= '0;
         bai   <= 1'b0;
      end
      else
      begin
         // One-cycle start pulse after the GO edge
         start <= goWrite;
         if (cs1Write && devLoByte)
            fun <= devDataIn[rhPkg::Cs1Fun +: rhPkg::FunWidth];
         // Clear wins, then GO, then end of count
         if (ctlClr)
            rdy <= 1'b1;
         else if (goWrite)
            rdy <= 1'b0;
         else if (wordDone && wc == 16'hffff)
            rdy <= 1'b1;
         // Word count, negative and counting up
         if (ctlClr)
            wc <= '0;
         else if (wcWrite)
         begin
            if (devHiByte)
               wc[15:8] <= devDataIn[15:8];
            if (devLoByte)
               wc[7:0] <= devDataIn[7:0];
         end
         else if (wordDone)
            wc <= wc + 16'd1;
         // Disk address
         if (ctlClr)
            da <= '0;
         else if (daWrite)
         begin
            if (devHiByte)
               da[15:8] <= devDataIn[15:8];
            if (devLoByte)
               da[7:0] <= devDataIn[7:0];
         end
         // BAI survives CLR, not the bus reset
         if (devReset)
            bai <= 1'b0;
         else if (cs2Write && devLoByte)
            bai <= devDataIn[rhPkg::Cs2Bai];
      end
   end

   assign wcCount = wc;
   assign daValue = da;

   //////////////////////////////////////////////////
   // Read-back
   //////////////////////////////////////////////////

   always_comb
   begin
      cs1Word = '0;
      cs1Word[rhPkg::Cs1Fun +: rhPkg::FunWidth] = fun;
      cs1Word[rhPkg::Cs1Rdy] = rdy;
      // BAE lives in the address register
      cs1Word[rhPkg::Cs1Bae +: rhPkg::BaeWidth] = busAddr[17:16];
      cs2Word = '0;
      cs2Word[rhPkg::Cs2Bai] = bai;
   end

   always_comb
   begin
      case (devSel)
         rhPkg::RegCs1: devDataOut = cs1Word;
         rhPkg::RegWc:  devDataOut = {20'd0, wc};
         rhPkg::RegBa:  devDataOut = {20'd0, busAddr[15:0]};
         rhPkg::RegDa:  devDataOut = {20'd0, da};
         rhPkg::RegCs2: devDataOut = cs2Word;
         default:       devDataOut = '0;
      endcase
   end

   // Words only move while a transfer is running
   assert property (@(posedge clk) disable iff (rst) wordDone |-> !rdy)
      else $error("rhRegs: wordDone while RDY is set");

endmodule

// ==== rtl/rhBusAddr.sv ====
`timescale 1ns/1ns

module rhBusAddr (
   input  logic              clk,
   input  logic              rst,
   input  logic              ctlClr,
   input  logic              cs1Write,
   input  logic              baWrite,
   input  logic              loByte,
   input  logic              hiByte,
   input  rhPkg::rhWord_t    dataIn,
   input  logic              rdy,
   input  logic              bai,
   input  logic              incBa,
   output rhPkg::rhAddr_t    busAddr
);

   //////////////////////////////////////////////////
   // Bus address register
   //////////////////////////////////////////////////

   // Word address, bits 17:1 only
   logic [17:1] addr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         addr <= '0;
      end
      else
      begin
         if (ctlClr)
            addr <= '0;
         // Extension bits come in through CS1
         else if (cs1Write && hiByte && rdy)
            addr[17:16] <= dataIn[rhPkg::Cs1Bae +: rhPkg::BaeWidth];
         else if (baWrite)
         begin
            if (hiByte)
               addr[15:8] <= dataIn[15:8];
            // Bit 0 of the low byte is dropped
            if (loByte)
               addr[7:1] <= dataIn[7:1];
         end
         // One word step per DMA transfer
         else if (incBa && !bai)
            addr <= addr + 17'd1;
      end
   end

   // Always an even byte address
   assign busAddr = {addr, 1'b0};

endmodule

// ==== rtl/rhDriveFeed.sv ====
`timescale 1ns/1ns

module rhDriveFeed (
   input  logic           clk,
   input  logic           rst,
   input  logic           ctlClr,
   input  logic           start,
   input  logic [15:0]    daValue,
   input  logic [15:0]    wcCount,
   rhSiloIf.producer      silo
);

   //////////////////////////////////////////////////
   // Drive model
   //////////////////////////////////////////////////

   // Words still to produce (WC of zero means 64K)
   logic [16:0] remaining;
   // Word index within the transfer
   logic [19:0] index;
   // Disk address held for the whole transfer
   logic [15:0] daLatch;

   // One word per cycle while the silo has room
   assign silo.push     = remaining != '0 && !silo.full;
   assign silo.pushData = {daLatch, index};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         remaining <= '0;
         index     <= '0;
      end
      else if (ctlClr)
      begin
         // Abort whatever is in flight
         remaining <= '0;
         index     <= '0;
      end
      else if (start)
      begin
         remaining <= 17'h10000 - {1'b0, wcCount};
         index     <= '0;
      end
      else if (silo.push)
      begin
         remaining <= remaining - 17'd1;
         index     <= index + 20'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         daLatch <= daValue;
   end

   // A new transfer never starts while words are still owed
   assert property (@(posedge clk) disable iff (rst) start |-> remaining == '0)
      else $error("rhDriveFeed: start while %0d words still to push", remaining);

endmodule

// ==== rtl/rhSilo.sv ====
`timescale 1ns/1ns

module rhSilo #(
   parameter int SiloDepth = 8
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       ctlClr,
   rhSiloIf.buffer    silo
);

   localparam int PtrWidth = $clog2(SiloDepth);
   localparam logic [PtrWidth:0] DepthCount = (PtrWidth + 1)'(SiloDepth);

   //////////////////////////////////////////////////
   // Storage and pointers
   //////////////////////////////////////////////////

   rhPkg::rhWord_t          mem [SiloDepth];
   logic [PtrWidth-1:0]     wrPtr;
   logic [PtrWidth-1:0]     rdPtr;
   // Occupancy is one bit wider than the pointers
   logic [PtrWidth:0]       count;
   logic                    pushOk;
   logic                    popOk;

   assign silo.full  = count == DepthCount;
   assign silo.empty = count == '0;

   // Head of the silo is valid while not empty
   assign silo.popData = mem[rdPtr];

   assign pushOk = silo.push && !silo.full;
   assign popOk  = silo.pop && !silo.empty;

   always_ff @(posedge clk)
   begin
      if (pushOk)
         mem[wrPtr] <= silo.pushData;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else if (ctlClr)
      begin
         // Flush drops the stored words
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (pushOk)
            wrPtr <= wrPtr + 1'b1;
         if (popOk)
            rdPtr <= rdPtr + 1'b1;
         case ({pushOk, popOk})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Occupancy must match the pointer distance
   assert property (@(posedge clk) disable iff (rst)
                    count[PtrWidth-1:0] == PtrWidth'(wrPtr - rdPtr))
      else $error("rhSilo: occupancy %0d disagrees with the pointers", count);

endmodule

// ==== rtl/rhBusWriter.sv ====
`timescale 1ns/1ns

module rhBusWriter (
   input  logic              clk,
   input  logic              rst,
   input  logic              ctlClr,
   input  logic              dmaStall,
   input  rhPkg::rhAddr_t    busAddr,
   rhSiloIf.consumer         silo,
   output logic              incBa,
   output logic              wordDone,
   output logic              dmaWrite,
   output rhPkg::rhAddr_t    dmaAddr,
   output rhPkg::rhWord_t    dmaData
);

   //////////////////////////////////////////////////
   // Pop control
   //////////////////////////////////////////////////

   // Take a word when one is there and the bus is free
   // No pop in the clear cycle while the silo is flushed
   assign silo.pop = !silo.empty && !dmaStall && !ctlClr;

   // Address and count advance with each pop
   assign incBa    = silo.pop;
   assign wordDone = silo.pop;

   //////////////////////////////////////////////////
   // DMA outputs
   //////////////////////////////////////////////////

   // Strobe one cycle after the pop
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dmaWrite <= 1'b0;
      end
      else
      begin
         dmaWrite <= silo.pop;
      end
   end

   // Address as it stood before the increment
   always_ff @(posedge clk)
   begin
      if (silo.pop)
      begin
         dmaAddr <= busAddr;
         dmaData <= silo.popData;
      end
   end

   // A word taken from the silo is always a written one
   assert property (@(posedge clk) disable iff (rst) silo.pop |-> !$isunknown(silo.popData))
      else $error("rhBusWriter: popped word is unknown");

endmodule

// ==== rtl/rhTop.sv ====
`timescale 1ns/1ns

module rhTop #(
   parameter int SiloDepth = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               devReset,
   input  rhPkg::rhRegSel_t   devSel,
   input  logic               devWrite,
   input  logic               devLoByte,
   input  logic               devHiByte,
   input  rhPkg::rhWord_t     devDataIn,
   input  logic               dmaStall,
   output rhPkg::rhWord_t     devDataOut,
   output logic               dmaWrite,
   output rhPkg::rhAddr_t     dmaAddr,
   output rhPkg::rhWord_t     dmaData,
   output logic               ready
);

   //////////////////////////////////////////////////
   // Internal nets
   //////////////////////////////////////////////////

   rhPkg::rhAddr_t   busAddr;
   logic             cs1Write;
   logic             baWrite;
   logic             ctlClr;
   logic             rdy;
   logic             bai;
   logic             start;
   logic             incBa;
   logic             wordDone;
   logic [15:0]      daValue;
   logic [15:0]      wcCount;

   // Drive side to bus side
   rhSiloIf #(.SiloDepth(SiloDepth)) siloBus ();

   rhRegs uRegs (
      .clk, .rst, .devReset, .devSel, .devWrite, .devLoByte, .devHiByte,
      .devDataIn, .busAddr, .wordDone, .devDataOut, .cs1Write, .baWrite,
      .ctlClr, .rdy, .bai, .start, .daValue, .wcCount
   );

   rhBusAddr uBusAddr (
      .clk, .rst, .ctlClr, .cs1Write, .baWrite,
      .loByte (devLoByte),
      .hiByte (devHiByte),
      .dataIn (devDataIn),
      .rdy, .bai, .incBa, .busAddr
   );

   rhDriveFeed uDriveFeed (
      .clk, .rst, .ctlClr, .start, .daValue, .wcCount,
      .silo (siloBus.producer)
   );

   rhSilo #(.SiloDepth(SiloDepth)) uSilo (
      .clk, .rst, .ctlClr,
      .silo (siloBus.buffer)
   );

   rhBusWriter uBusWriter (
      .clk, .rst, .ctlClr, .dmaStall, .busAddr,
      .silo (siloBus.consumer),
      .incBa, .wordDone, .dmaWrite, .dmaAddr, .dmaData
   );

   assign ready = rdy;

endmodule

// ==== verification/rhChecker.sv ====
`timescale 1ns/1ns

module rhChecker (
   input  logic               clk,
   input  logic               rst,
   // DUT outputs under watch
   input  logic               dmaWrite,
   input  rhPkg::rhAddr_t     dmaAddr,
   input  rhPkg::rhWord_t     dmaData,
   input  rhPkg::rhWord_t     devDataOut,
   input  rhPkg::rhRegSel_t   devSel,
   input  logic               ready,
   // Test control from the testbench
   input  logic               armed,
   input  logic               testStart,
   input  logic               testEnd,
   input  rhPkg::rhAddr_t     expBase,
   input  logic [15:0]        expDa,
   input  logic               expBai,
   input  int                 expWords,
   input  logic               partialOk,
   input  logic               readChk,
   input  rhPkg::rhWord_t     readExp,
   // Running totals
   output int                 seenWords,
   output int                 errorCount,
   output int                 checkCount,
   output int                 testCount
);

   int               testErrors;
   rhPkg::rhAddr_t   expAddr;
   rhPkg::rhWord_t   expData;

   //////////////////////////////////////////////////
   // Reporting helpers
   //////////////////////////////////////////////////

   function automatic string regName(rhPkg::rhRegSel_t sel);
      case (sel)
         rhPkg::RegCs1: return "devDataOut(CS1)";
         rhPkg::RegWc:  return "devDataOut(WC)";
         rhPkg::RegBa:  return "devDataOut(BA)";
         rhPkg::RegDa:  return "devDataOut(DA)";
         rhPkg::RegCs2: return "devDataOut(CS2)";
         default:       return "devDataOut(unmapped)";
      endcase
   endfunction

   task automatic reportMismatch(string name, logic [35:0] expVal, logic [35:0] gotVal);
      $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expVal, gotVal);
      errorCount++;
      testErrors++;
   endtask

   task automatic reportFailure(string what);
      $display("Error at %0t ns: %s", $time, what);
      errorCount++;
      testErrors++;
   endtask

   //////////////////////////////////////////////////
   // Model and compare
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (!rst)
      begin
         if (testStart)
         begin
            seenWords  = 0;
            testErrors = 0;
         end
         // One DMA word per strobe
         if (dmaWrite)
         begin
            if (!armed)
               reportFailure("dmaWrite seen with no transfer running");
            else if (seenWords >= expWords)
               reportFailure($sformatf("dmaWrite beyond the %0d words asked for", expWords));
            else
            begin
               // Address steps by one word unless increment is inhibited
               expAddr = expBai ? expBase : expBase + rhPkg::rhAddr_t'(2 * seenWords);
               // Drive pattern with DA on top and word index below
               expData = {expDa, 20'(seenWords)};
               checkCount += 2;
               if (dmaAddr !== expAddr)
                  reportMismatch("dmaAddr", 36'(expAddr), 36'(dmaAddr));
               if (dmaData !== expData)
                  reportMismatch("dmaData", expData, dmaData);
            end
            seenWords++;
         end
         // Register read-back with devDataOut settled since the select change
         if (readChk)
         begin
            checkCount++;
            if (devDataOut !== readExp)
               reportMismatch(regName(devSel), readExp, devDataOut);
            // The ready pin follows the RDY bit of CS1
            if (devSel == rhPkg::RegCs1)
            begin
               checkCount++;
               if (ready !== readExp[rhPkg::Cs1Rdy])
                  reportMismatch("ready", 36'(readExp[rhPkg::Cs1Rdy]), 36'(ready));
            end
         end
         if (testEnd)
         begin
            // An aborted transfer has no fixed length
            if (!partialOk)
            begin
               checkCount++;
               if (seenWords != expWords)
                  reportMismatch("wordCount", 36'(expWords), 36'(seenWords));
            end
            testCount++;
            $display("Test %0d finished: %0d words, %0d errors",
                     testCount, seenWords, testErrors);
         end
      end
   end

endmodule

// ==== verification/rhTb.sv ====
`timescale 1ns/1ns

module rhTb;

   localparam int NumRows = 9;
   // BA value written before the lane test write
   localparam logic [15:0] BaPreset = 16'hc3c5;

   // One transfer per row
   typedef struct packed {
      logic [15:0] da;
      logic [15:0] ba;
      logic [1:0]  bae;
      logic [1:0]  lanes;
      logic [7:0]  words;
      logic        bai;
      logic [1:0]  stall;
      logic [7:0]  clearAfter;
   } testRow_t;

   logic clk;
   logic rst;
   logic devReset;
   rhPkg::rhRegSel_t devSel;
   logic devWrite;
   logic devLoByte;
   logic devHiByte;
   rhPkg::rhWord_t devDataIn;
   logic dmaStall;
   rhPkg::rhWord_t devDataOut;
   logic dmaWrite;
   rhPkg::rhAddr_t dmaAddr;
   rhPkg::rhWord_t dmaData;
   logic ready;

   // Checker control
   logic armed;
   logic testStart;
   logic testEnd;
   rhPkg::rhAddr_t expBase;
   logic [15:0] expDa;
   logic expBai;
   int expWords;
   logic partialOk;
   logic readChk;
   rhPkg::rhWord_t readExp;
   int seenWords;
   int errorCount;
   int checkCount;
   int testCount;

   testRow_t testTable [NumRows];
   logic [31:0] lcgState;
   logic [4:0] funNow;
   int cycleLimit;
   int cycleCount;

   rhTop #(.SiloDepth(8)) dut (
      .clk, .rst, .devReset, .devSel, .devWrite, .devLoByte, .devHiByte,
      .devDataIn, .dmaStall, .devDataOut, .dmaWrite, .dmaAddr, .dmaData, .ready
   );

   rhChecker chk (
      .clk, .rst, .dmaWrite, .dmaAddr, .dmaData, .devDataOut, .devSel, .ready,
      .armed, .testStart, .testEnd, .expBase, .expDa, .expBai, .expWords,
      .partialOk, .readChk, .readExp, .seenWords, .errorCount, .checkCount, .testCount
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // Timeout
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("Timeout: run still busy after %0d cycles", cycleCount);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Expected CS1 image from its fields
   function automatic rhPkg::rhWord_t cs1Value(logic [4:0] fun, logic [1:0] bae);
      return (36'(fun) << rhPkg::Cs1Fun) | (36'd1 << rhPkg::Cs1Rdy) |
             (36'(bae) << rhPkg::Cs1Bae);
   endfunction

   // Lanes are {high, low}
   // Takes one cycle and returns 1 ns after the edge
   task automatic writeReg(rhPkg::rhRegSel_t sel, rhPkg::rhWord_t data, logic [1:0] lanes);
      devSel    = sel;
      devDataIn = data;
      devHiByte = lanes[1];
      devLoByte = lanes[0];
      devWrite  = 1'b1;
      @(posedge clk);
      #1;
      devWrite  = 1'b0;
      devHiByte = 1'b0;
      devLoByte = 1'b0;
   endtask

   task automatic readCheck(rhPkg::rhRegSel_t sel, rhPkg::rhWord_t expVal);
      devSel  = sel;
      readExp = expVal;
      readChk = 1'b1;
      @(posedge clk);
      #1;
      readChk = 1'b0;
   endtask

   // da, ba, bae, lanes, words, bai, stall mode, clear after
   task automatic fillTable();
      testTable[0] = '{16'h1234, 16'h0400, 2'd0, 2'b11, 8'd8,  1'b0, 2'd0, 8'd0};
      testTable[1] = '{16'hbeef, 16'h1ff0, 2'd3, 2'b11, 8'd12, 1'b0, 2'd0, 8'd0};
      testTable[2] = '{16'h0f0f, 16'h2222, 2'd1, 2'b11, 8'd6,  1'b1, 2'd0, 8'd0};
      testTable[3] = '{16'h7e57, 16'h8000, 2'd2, 2'b11, 8'd20, 1'b0, 2'd1, 8'd0};
      testTable[4] = '{16'h5a5a, 16'h0100, 2'd0, 2'b11, 8'd16, 1'b0, 2'd2, 8'd0};
      testTable[5] = '{16'h0001, 16'hffaa, 2'd1, 2'b01, 8'd5,  1'b0, 2'd0, 8'd0};
      testTable[6] = '{16'h00a0, 16'h3700, 2'd0, 2'b10, 8'd4,  1'b0, 2'd1, 8'd0};
      testTable[7] = '{16'hcafe, 16'h4000, 2'd2, 2'b11, 8'd30, 1'b0, 2'd1, 8'd5};
      // Wraps past the top of the 18-bit space
      testTable[8] = '{16'h0042, 16'hfff8, 2'd3, 2'b11, 8'd8,  1'b0, 2'd0, 8'd0};
   endtask

   //////////////////////////////////////////////////
   // One table row
   //////////////////////////////////////////////////

   task automatic runRow(testRow_t row);
      logic [15:0]      baLo;
      rhPkg::rhAddr_t   base;
      rhPkg::rhAddr_t   finalAddr;
      int               stallCycle;
      logic             clearDone;
      // BA after preset and lane write with bit 0 dropped
      baLo[15:8] = row.lanes[1] ? row.ba[15:8] : BaPreset[15:8];
      baLo[7:0]  = row.lanes[0] ? row.ba[7:0] : BaPreset[7:0];
      baLo[0]    = 1'b0;
      base       = {row.bae, baLo};
      finalAddr  = row.bai ? base : base + rhPkg::rhAddr_t'(2 * row.words);
      writeReg(rhPkg::RegCs2, 36'(row.bai) << rhPkg::Cs2Bai, 2'b01);
      writeReg(rhPkg::RegDa, 36'(row.da), 2'b11);
      // Word count is negative
      writeReg(rhPkg::RegWc, 36'(16'd0 - 16'(row.words)), 2'b11);
      writeReg(rhPkg::RegBa, 36'(BaPreset), 2'b11);
      writeReg(rhPkg::RegBa, 36'(row.ba), row.lanes);
      // BAE through the CS1 high byte while idle
      writeReg(rhPkg::RegCs1, 36'(row.bae) << rhPkg::Cs1Bae, 2'b10);
      readCheck(rhPkg::RegBa, 36'(baLo));
      readCheck(rhPkg::RegCs1, cs1Value(funNow, row.bae));
      expBase   = base;
      expDa     = row.da;
      expBai    = row.bai;
      expWords  = row.words;
      partialOk = row.clearAfter != 0;
      armed     = 1'b1;
      testStart = 1'b1;
      @(posedge clk);
      #1;
      testStart = 1'b0;
      // GO with the read function
      writeReg(rhPkg::RegCs1, (36'(rhPkg::FunRead) << rhPkg::Cs1Fun) | 36'd1, 2'b01);
      funNow = rhPkg::FunRead;
      // Busy now so this BAE value must be ignored
      writeReg(rhPkg::RegCs1, 36'(~row.bae) << rhPkg::Cs1Bae, 2'b10);
      // Busy with RDY low and BAE unchanged
      readCheck(rhPkg::RegCs1, cs1Value(funNow, row.bae) & ~(36'd1 << rhPkg::Cs1Rdy));
      stallCycle = 0;
      clearDone  = 1'b0;
      while (!ready)
      begin
         case (row.stall)
            2'd1:    dmaStall = nextRandom() >= 32'h8000_0000;
            2'd2:    dmaStall = stallCycle < 12;
            default: dmaStall = 1'b0;
         endcase
         if (row.clearAfter != 0 && !clearDone && seenWords >= row.clearAfter)
         begin
            // Controller clear mid-transfer
            clearDone = 1'b1;
            writeReg(rhPkg::RegCs2, (36'(row.bai) << rhPkg::Cs2Bai) |
                     (36'd1 << rhPkg::Cs2Clr), 2'b01);
            armed = 1'b0;
         end
         else
         begin
            @(posedge clk);
            #1;
         end
         stallCycle++;
      end
      dmaStall = 1'b0;
      if (clearDone)
      begin
         readCheck(rhPkg::RegBa, '0);
         readCheck(rhPkg::RegWc, '0);
         readCheck(rhPkg::RegDa, '0);
         readCheck(rhPkg::RegCs1, cs1Value(funNow, 2'd0));
      end
      else
      begin
         readCheck(rhPkg::RegWc, '0);
         readCheck(rhPkg::RegBa, 36'(finalAddr[15:0]));
         readCheck(rhPkg::RegCs1, cs1Value(funNow, finalAddr[17:16]));
      end
      testEnd = 1'b1;
      @(posedge clk);
      #1;
      testEnd = 1'b0;
      armed   = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      clk       = 1'b0;
      rst       = 1'b1;
      devReset  = 1'b0;
      devSel    = rhPkg::RegCs1;
      devWrite  = 1'b0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
      devDataIn = '0;
      dmaStall  = 1'b0;
      armed     = 1'b0;
      testStart = 1'b0;
      testEnd   = 1'b0;
      expBase   = '0;
      expDa     = '0;
      expBai    = 1'b0;
      expWords  = 0;
      partialOk = 1'b0;
      readChk   = 1'b0;
      readExp   = '0;
      lcgState  = 32'h9be5_8b7a;
      funNow    = '0;
      cycleCount = 0;
      fillTable();
      // Four cycles per word plus setup slack
      cycleLimit = 200;
      for (int i = 0; i < NumRows; i++)
         cycleLimit += 4 * testTable[i].words;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      #1;
      for (int i = 0; i < NumRows; i++)
         runRow(testTable[i]);
      repeat (2) @(posedge clk);
      $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0 && testCount == NumRows)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== files.f ====
rtl/rhPkg.sv
rtl/rhSiloIf.sv
rtl/rhRegs.sv
rtl/rhBusAddr.sv
rtl/rhDriveFeed.sv
rtl/rhSilo.sv
rtl/rhBusWriter.sv
rtl/rhTop.sv
verification/rhChecker.sv
verification/rhTb.sv

// ==== Makefile ====
# Verilator simulation of the RH11 data path

VERILATOR ?= verilator
TOP       ?= rhTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
